//--- compile.f
+incdir+verilog
verilog/id_pkg.sv
verilog/id_gpr.sv
verilog/id_decoder.sv
verilog/id_hazard_fwd.sv
verilog/id_branch.sv
verilog/id_stage.sv
tests/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --assert -f compile.f --top-module tb_id_stage \
    -Mdir obj_dir -o tb_id_stage &&
  ./obj_dir/tb_id_stage ||
  { echo "simulation failed"; exit 1; }

//--- tests/tb_id_stage.sv
// directed tests for the decode stage; needs a simulator with timing support, stops at the first error
`default_nettype none
`timescale 1ns/1ns
`include "id_defs.svh"

module tb_id_stage;

  localparam int TIMEOUT = 20; // cycles per wait loop

  logic              clk;
  logic              arst_n;
  logic              fs_valid;
  id_pkg::fs_to_ds_t fs_bus;
  logic              ds_allowin;
  logic              es_allowin;
  logic              es_valid;
  id_pkg::ds_to_es_t es_bus;
  id_pkg::br_bus_t   br_bus;
  id_pkg::rf_wr_t    rf_wr;
  id_pkg::bypass_t   es_byp;
  id_pkg::bypass_t   ms_byp;
  id_pkg::bypass_t   ws_byp;
  logic              es_load_sel;
  integer            seed;
  logic [63:0]       x1_val;
  logic [63:0]       x2_val;

  id_stage dut0 (
    .i_clk            (clk),
    .i_arst_n         (arst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (es_valid),
    .o_ds_to_es_bus   (es_bus),
    .o_br_bus         (br_bus),
    .i_ws_to_rf       (rf_wr),
    .i_es_byp         (es_byp),
    .i_ms_byp         (ms_byp),
    .i_ws_byp         (ws_byp),
    .i_es_load_sel    (es_load_sel)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("timed out while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "wait loop timeout");
  endtask

  function automatic logic [31:0] rnd32();
    return $random(seed);
  endfunction

  // rv64i encodings and sign-extension rules
  function automatic logic [31:0] r_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [6:0] f7, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] sext13(input logic [12:0] v);
    return {{51{v[12]}}, v};
  endfunction

  function automatic logic [63:0] sext21(input logic [20:0] v);
    return {{43{v[20]}}, v};
  endfunction

  function automatic logic [63:0] upper_imm(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic settle();
    #1;
  endtask

  task automatic rf_write(input logic [4:0] addr, input logic [63:0] data);
    step();
    rf_wr.wen = 1'b1;
    rf_wr.waddr = addr;
    rf_wr.wdata = data;
    step();
    rf_wr.wen = 1'b0;
  endtask

  // one idle cycle first, so a redirect still in the stage cannot squash this one
  task automatic send(input logic [31:0] inst, input logic [63:0] pc);
    int n;
    step();
    fs_valid = 1'b1;
    fs_bus.inst = inst;
    fs_bus.pc = pc;
    n = 0;
    #1;
    while (!ds_allowin) begin
      if (n == TIMEOUT) give_up("the decode stage to accept an instruction");
      @(posedge clk);
      #3;
      n++;
    end
    step();
    fs_valid = 1'b0;
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    #1;
    while (!es_valid) begin
      if (n == TIMEOUT) give_up("the decode output valid after a stall");
      step();
      #1;
      n++;
    end
  endtask

  task automatic test_reset_state();
    settle();
    check(64'(es_valid), 64'd0, "output valid after reset");
    check(64'(br_bus.taken), 64'd0, "redirect taken after reset");
    check(64'(br_bus.sel), 64'd0, "redirect sel after reset");
    check(64'(ds_allowin), 64'd1, "allowin after reset");
  endtask

  task automatic test_rf_rtype();
    x1_val = {rnd32(), rnd32()};
    x2_val = {rnd32(), rnd32()};
    rf_write(5'd1, x1_val);
    rf_write(5'd2, x2_val);
    send(r_word(`OPC_OP, 3'b000, 7'h00, 5'd3, 5'd1, 5'd2), 64'h1000);
    settle();
    check(es_bus.rs1data, x1_val, "add rs1data");
    check(es_bus.rs2data, x2_val, "add rs2data");
    check(64'(es_bus.rd), 64'd3, "add rd");
    check(64'(es_bus.alu_op), 64'(id_pkg::ALU_ADD), "add alu_op");
    check(64'(es_bus.gpr_wen), 64'd1, "add gpr_wen");
    check(64'(es_valid), 64'd1, "add output valid");
    rf_write(5'd0, {rnd32(), rnd32()}); // must be dropped
    send(r_word(`OPC_OP, 3'b000, 7'h00, 5'd4, 5'd0, 5'd0), 64'h1004);
    settle();
    check(es_bus.rs1data, 64'd0, "x0 read on rs1");
    check(es_bus.rs2data, 64'd0, "x0 read on rs2");
  endtask

  task automatic test_forwarding();
    logic [63:0] es_res;
    logic [63:0] ms_res;
    logic [63:0] ws_res;
    es_res = {rnd32(), rnd32()};
    ms_res = {rnd32(), rnd32()};
    ws_res = {rnd32(), rnd32()};
    send(r_word(`OPC_OP, 3'b000, 7'h00, 5'd3, 5'd1, 5'd2), 64'h1008);
    es_byp = '{rd: 5'd1, result: es_res};
    ms_byp = '{rd: 5'd1, result: ms_res};
    ws_byp = '{rd: 5'd1, result: ws_res};
    settle();
    check(es_bus.rs1data, es_res, "es result has priority");
    step();
    es_byp.rd = 5'd0;
    settle();
    check(es_bus.rs1data, ms_res, "ms result when es rd is x0");
    step();
    es_byp.rd = 5'd7;
    settle();
    check(es_bus.rs1data, ms_res, "ms result when es rd differs");
    step();
    ms_byp.rd = 5'd0;
    settle();
    check(es_bus.rs1data, ws_res, "ws result");
    step();
    ws_byp.rd = 5'd0;
    es_byp.rd = 5'd0;
    settle();
    check(es_bus.rs1data, x1_val, "register file when nothing matches");
  endtask

  task automatic test_stalls();
    send(r_word(`OPC_OP, 3'b000, 7'h00, 5'd3, 5'd1, 5'd2), 64'h1010);
    es_load_sel = 1'b1;
    es_byp = '{rd: 5'd2, result: {rnd32(), rnd32()}};
    repeat (3) begin
      settle();
      check(64'(es_valid), 64'd0, "output valid during load-use stall");
      check(64'(ds_allowin), 64'd0, "allowin during load-use stall");
      step();
    end
    es_load_sel = 1'b0;
    es_byp.rd = 5'd0;
    wait_out_valid();
    check(es_bus.rs2data, x2_val, "rs2data after load-use stall");
    send(`EBREAK_INST, 64'h1014);
    ms_byp.rd = `GPR_A0; // a0 still in memory stage
    repeat (3) begin
      settle();
      check(64'(es_valid), 64'd0, "output valid during ebreak stall");
      check(64'(ds_allowin), 64'd0, "allowin during ebreak stall");
      step();
    end
    ms_byp.rd = 5'd0;
    wait_out_valid();
    check(64'(es_bus.ebreak_sel), 64'd1, "ebreak_sel");
  endtask

  task automatic test_branches();
    logic [31:0] r;
    logic [12:0] boff;
    logic [11:0] joff;
    logic [63:0] pc;
    logic [63:0] target;
    r = rnd32();
    boff = {r[12:6], 1'b1, r[4:1], 1'b0}; // bit 5 set so never +4
    joff = r[31:20];
    pc = 64'h0000_0000_8000_0100;
    target = pc + sext13(boff);
    send(b_word(3'b000, 5'd1, 5'd1, boff), pc);
    fs_valid = 1'b1;
    fs_bus.inst = r_word(`OPC_OP, 3'b000, 7'h00, 5'd9, 5'd1, 5'd2);
    fs_bus.pc = pc + 64'd4;
    settle();
    check(64'(br_bus.sel), 64'd1, "beq sel");
    check(br_bus.target, target, "beq target");
    check(64'(br_bus.taken), 64'd1, "beq taken");
    step();
    fs_valid = 1'b0;
    settle();
    check(64'(es_bus.rd), 64'd0, "squashed instruction rd");
    check(es_bus.imm, 64'd0, "squashed instruction imm");
    check(es_bus.pc, pc + 64'd4, "squashed instruction pc");
    check(64'(br_bus.sel), 64'd0, "no redirect from squashed instruction");
    send(b_word(3'b000, 5'd1, 5'd1, boff), pc);
    fs_bus.pc = target;
    settle();
    check(64'(br_bus.sel), 64'd1, "beq sel with fetch on target");
    check(64'(br_bus.taken), 64'd0, "no taken when fetch pc is the target");
    send(b_word(3'b001, 5'd1, 5'd1, boff), pc);
    settle();
    check(64'(br_bus.sel), 64'd0, "bne equal operands sel");
    check(64'(br_bus.taken), 64'd0, "bne equal operands taken");
    target = x2_val + sext12(joff);
    target[0] = 1'b0;
    send(i_word(`OPC_JALR, 3'b000, 5'd1, 5'd2, joff), pc);
    settle();
    check(64'(br_bus.sel), 64'd1, "jalr sel");
    check(br_bus.target, target, "jalr target");
  endtask

  task automatic test_backpressure();
    id_pkg::ds_to_es_t snap;
    step();
    es_allowin = 1'b0;
    send(r_word(`OPC_OP, 3'b000, 7'h00, 5'd5, 5'd1, 5'd2), 64'h2000);
    settle();
    snap = es_bus;
    check(64'(snap.rd), 64'd5, "held instruction rd");
    check(snap.pc, 64'h2000, "held instruction pc");
    repeat (4) begin
      step();
      fs_valid = 1'b1;
      fs_bus.inst = rnd32();
      fs_bus.pc = {rnd32(), rnd32()};
      settle();
      check(64'(ds_allowin), 64'd0, "allowin under back-pressure");
      check(64'(es_valid), 64'd1, "output valid under back-pressure");
      check(64'(es_bus == snap), 64'd1, "output bus held under back-pressure");
    end
    step();
    fs_valid = 1'b0;
    es_allowin = 1'b1;
  endtask

  task automatic test_immediates();
    logic [31:0] r;
    repeat (4) begin
      r = rnd32();
      send(i_word(`OPC_OPIMM, 3'b000, 5'd6, 5'd1, r[11:0]), 64'h3000);
      settle();
      check(es_bus.imm, sext12(r[11:0]), "I immediate");
      r = rnd32();
      send(s_word(3'b011, 5'd1, 5'd2, r[11:0]), 64'h3004);
      settle();
      check(es_bus.imm, sext12(r[11:0]), "S immediate");
      check(64'(es_bus.mem_wen), 64'd1, "store mem_wen");
      r = rnd32();
      send(u_word(`OPC_LUI, 5'd7, r[19:0]), 64'h3008);
      settle();
      check(es_bus.imm, upper_imm(r[19:0]), "U immediate");
      check(64'(es_bus.alu_op), 64'(id_pkg::ALU_PASS_B), "lui alu_op");
      check(64'(es_bus.alu_src2_sel), 64'd1, "lui operand b is imm");
      r = rnd32();
      send(j_word(5'd1, {r[20:1], 1'b0}), 64'h300c);
      settle();
      check(es_bus.imm, sext21({r[20:1], 1'b0}), "J immediate");
      check(64'(es_bus.alu_src1_sel), 64'd1, "jal link operand a is pc");
      check(64'(es_bus.alu_src2_sel), 64'd2, "jal link operand b is 4");
    end
    send(i_word(7'b0001111, 3'b000, 5'd1, 5'd1, 12'h000), 64'h3010); // fence
    settle();
    check(64'(es_bus.invalid_sel), 64'd1, "unsupported opcode invalid_sel");
    check(64'(es_bus.gpr_wen), 64'd0, "unsupported opcode gpr_wen");
    check(64'(es_bus.mem_ren), 64'd0, "unsupported opcode mem_ren");
    check(64'(es_bus.mem_wen), 64'd0, "unsupported opcode mem_wen");
    send(i_word(`OPC_LOAD, 3'b011, 5'd8, 5'd1, 12'h010), 64'h3014); // ld
    settle();
    check(64'(es_bus.load_sel), 64'd1, "ld load_sel");
    check(64'(es_bus.mem_ren), 64'd1, "ld mem_ren");
    check(64'(es_bus.mem_op), 64'd3, "ld mem_op");
    send(r_word(`OPC_OP32, 3'b000, 7'h20, 5'd9, 5'd1, 5'd2), 64'h3018); // subw
    settle();
    check(64'(es_bus.alu_word_cut), 64'd1, "subw alu_word_cut");
    check(64'(es_bus.alu_op), 64'(id_pkg::ALU_SUB), "subw alu_op");
  endtask

  initial begin
    seed = 32'h52fa5fe8;
    arst_n = 1'b0;
    fs_valid = 1'b0;
    fs_bus = '0;
    es_allowin = 1'b1;
    rf_wr = '0;
    es_byp = '0;
    ms_byp = '0;
    ws_byp = '0;
    es_load_sel = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    test_reset_state();
    test_rf_rtype();
    test_forwarding();
    test_stalls();
    test_branches();
    test_backpressure();
    test_immediates();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
// decode stage top; redirect is not held back by a stall, so a branch on a pending load may mispredict
`default_nettype none
`timescale 1ns/1ns
`include "id_defs.svh"

module id_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t   i_fs_to_ds_bus,
  output logic                o_ds_allowin,
  input  logic                i_es_allowin,
  output logic                o_ds_to_es_valid,
  output id_pkg::ds_to_es_t   o_ds_to_es_bus,
  output id_pkg::br_bus_t     o_br_bus,
  input  id_pkg::rf_wr_t      i_ws_to_rf,
  input  id_pkg::bypass_t     i_es_byp,
  input  id_pkg::bypass_t     i_ms_byp,
  input  id_pkg::bypass_t     i_ws_byp,
  input  logic                i_es_load_sel
);

  logic              ds_valid;
  logic              ds_ready_go;
  logic              stall;
  logic              br_sel_raw;
  logic              br_sel;
  logic [`XLEN-1:0]  br_target;
  logic [`XLEN-1:0]  rf_rdata1;
  logic [`XLEN-1:0]  rf_rdata2;
  logic [`XLEN-1:0]  rs1data;
  logic [`XLEN-1:0]  rs2data;
  id_pkg::fs_to_ds_t ds_r;
  id_pkg::ctrl_t     ctrl;

  assign ds_ready_go      = !stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
      ds_r.inst <= `NOP_INST;
      ds_r.pc <= '0;
    end else begin
      if (o_ds_allowin) begin
        ds_valid <= i_fs_to_ds_valid;
      end
      if (i_fs_to_ds_valid && o_ds_allowin) begin
        // the sequential fetch behind a taken redirect is squashed
        ds_r.inst <= o_br_bus.taken ? `NOP_INST : i_fs_to_ds_bus.inst;
        ds_r.pc <= i_fs_to_ds_bus.pc;
      end
    end
  end

  assign br_sel          = ds_valid && br_sel_raw;
  assign o_br_bus.sel    = br_sel;
  assign o_br_bus.target = br_target;
  assign o_br_bus.taken  = br_sel && (br_target != i_fs_to_ds_bus.pc);

  always_comb begin
    o_ds_to_es_bus.load_sel = ctrl.load_sel;
    o_ds_to_es_bus.rs1data = rs1data;
    o_ds_to_es_bus.rs2data = rs2data;
    o_ds_to_es_bus.imm = ctrl.imm;
    o_ds_to_es_bus.pc = ds_r.pc;
    o_ds_to_es_bus.alu_src1_sel = ctrl.alu_src1_sel;
    o_ds_to_es_bus.alu_src2_sel = ctrl.alu_src2_sel;
    o_ds_to_es_bus.alu_word_cut = ctrl.alu_word_cut;
    o_ds_to_es_bus.alu_op = ctrl.alu_op;
    o_ds_to_es_bus.rd = ctrl.rd;
    o_ds_to_es_bus.gpr_wen = ctrl.gpr_wen;
    o_ds_to_es_bus.mem_ren = ctrl.mem_ren;
    o_ds_to_es_bus.mem_wen = ctrl.mem_wen;
    o_ds_to_es_bus.mem_op = ctrl.mem_op;
    o_ds_to_es_bus.ebreak_sel = ctrl.ebreak_sel;
    o_ds_to_es_bus.invalid_sel = ctrl.invalid_sel;
  end

  id_gpr u_gpr (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (ctrl.rs1),
    .i_raddr2 (ctrl.rs2),
    .i_wr     (i_ws_to_rf),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_decoder u_decoder (
    .i_inst (ds_r.inst),
    .o_ctrl (ctrl)
  );

  id_hazard_fwd u_hazard_fwd (
    .i_rs1         (ctrl.rs1),
    .i_rs2         (ctrl.rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_byp      (i_es_byp),
    .i_ms_byp      (i_ms_byp),
    .i_ws_byp      (i_ws_byp),
    .i_es_load_sel (i_es_load_sel),
    .i_ebreak_sel  (ctrl.ebreak_sel),
    .o_rs1data     (rs1data),
    .o_rs2data     (rs2data),
    .o_stall       (stall)
  );

  id_branch u_branch (
    .i_br_kind   (ctrl.br_kind),
    .i_br_func   (ctrl.br_func),
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .i_pc        (ds_r.pc),
    .i_imm       (ctrl.imm),
    .o_br_sel    (br_sel_raw),
    .o_br_target (br_target)
  );

  a_out_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_ds_to_es_valid |-> ds_valid);

  // taken only ever comes from a selected redirect
  a_taken_sel: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_br_bus.taken |-> o_br_bus.sel);

endmodule

`default_nettype wire

//--- verilog/id_branch.sv
// branch compare and target; jalr clears bit 0, misaligned targets are not flagged
`default_nettype none
`timescale 1ns/1ns
`include "id_defs.svh"

module id_branch (
  input  id_pkg::br_kind_e i_br_kind,
  input  logic [2:0]       i_br_func,
  input  logic [`XLEN-1:0] i_rs1data,
  input  logic [`XLEN-1:0] i_rs2data,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_imm,
  output logic             o_br_sel,
  output logic [`XLEN-1:0] o_br_target
);

  logic             cond;
  logic [`XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_br_func)
      3'b000:  cond = (i_rs1data == i_rs2data);                   // beq
      3'b001:  cond = (i_rs1data != i_rs2data);                   // bne
      3'b100:  cond = ($signed(i_rs1data) < $signed(i_rs2data));  // blt
      3'b101:  cond = ($signed(i_rs1data) >= $signed(i_rs2data)); // bge
      3'b110:  cond = (i_rs1data < i_rs2data);
      3'b111:  cond = (i_rs1data >= i_rs2data);
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + i_imm;

  assign o_br_sel = (i_br_kind == id_pkg::BR_JAL) || (i_br_kind == id_pkg::BR_JALR) ||
                    (i_br_kind == id_pkg::BR_COND && cond);

  assign o_br_target = (i_br_kind == id_pkg::BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                                      : i_pc + i_imm;

  always_comb begin
    a_no_sel_idle: assert final (!(o_br_sel && i_br_kind == id_pkg::BR_NONE))
      else $error("redirect from a non-branch instruction");
  end

endmodule

`default_nettype wire

//--- verilog/id_hazard_fwd.sv
// es/ms/ws forwarding in that order; bypass rd is expected to be zero when a stage is empty
`default_nettype none
`timescale 1ns/1ns
`include "id_defs.svh"

module id_hazard_fwd (
  input  logic [`GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`GPR_ADDR_WD-1:0] i_rs2,
  input  logic [`XLEN-1:0]        i_rf_rdata1,
  input  logic [`XLEN-1:0]        i_rf_rdata2,
  input  id_pkg::bypass_t         i_es_byp,
  input  id_pkg::bypass_t         i_ms_byp,
  input  id_pkg::bypass_t         i_ws_byp,
  input  logic                    i_es_load_sel,
  input  logic                    i_ebreak_sel,
  output logic [`XLEN-1:0]        o_rs1data,
  output logic [`XLEN-1:0]        o_rs2data,
  output logic                    o_stall
);

  logic load_stall;
  logic ebreak_stall;

  function automatic logic hit(input id_pkg::bypass_t byp,
                               input logic [`GPR_ADDR_WD-1:0] rs);
    return (byp.rd != '0) && (byp.rd == rs);
  endfunction

  function automatic logic [`XLEN-1:0] pick(input logic [`GPR_ADDR_WD-1:0] rs,
                                            input logic [`XLEN-1:0] rf);
    if (hit(i_es_byp, rs)) return i_es_byp.result; // youngest first
    if (hit(i_ms_byp, rs)) return i_ms_byp.result;
    if (hit(i_ws_byp, rs)) return i_ws_byp.result;
    return rf;
  endfunction

  always_comb begin
    o_rs1data = pick(i_rs1, i_rf_rdata1);
    o_rs2data = pick(i_rs2, i_rf_rdata2);
  end

  // load data not back until mem stage
  assign load_stall = i_es_load_sel && (hit(i_es_byp, i_rs1) || hit(i_es_byp, i_rs2));

  // ebreak waits for a0 to retire
  assign ebreak_stall = i_ebreak_sel && (i_es_byp.rd == `GPR_A0 ||
                                         i_ms_byp.rd == `GPR_A0 ||
                                         i_ws_byp.rd == `GPR_A0);

  assign o_stall = load_stall || ebreak_stall;

endmodule

`default_nettype wire

//--- verilog/id_decoder.sv
// rv64i base decode only; csr, fence, ecall and mret come out as invalid
`default_nettype none
`timescale 1ns/1ns
`include "id_defs.svh"

module id_decoder (
  input  id_pkg::inst_u i_inst,
  output id_pkg::ctrl_t o_ctrl
);

  logic [2:0]       f3;
  logic [6:0]       f7;
  logic             op_ok;
  logic             sh_ok;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign f3 = i_inst.r.funct3;
  assign f7 = i_inst.r.funct7;

  assign imm_i = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_s = {{52{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
  assign imm_b = {{52{i_inst.b.imm12}}, i_inst.b.imm11, i_inst.b.imm10_5,
                  i_inst.b.imm4_1, 1'b0};
  assign imm_u = {{32{i_inst.u.imm[19]}}, i_inst.u.imm, 12'h000};
  assign imm_j = {{44{i_inst.j.imm20}}, i_inst.j.imm19_12, i_inst.j.imm11,
                  i_inst.j.imm10_1, 1'b0};

  // funct7 is either base or alt, alt only for sub and sra
  assign op_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
  // 64-bit immediate shifts use a 6-bit shamt, so only funct6 is checked
  assign sh_ok = (f3 != 3'b001 && f3 != 3'b101) || (f7[6:1] == 6'h00) ||
                 (f3 == 3'b101 && f7[6:1] == 6'h10);

  function automatic id_pkg::alu_op_e alu_dec(input logic [2:0] fn, input logic alt);
    case (fn)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    logic ok;
    ok = 1'b1;
    o_ctrl = '0;
    o_ctrl.br_kind = id_pkg::BR_NONE;
    o_ctrl.alu_op = id_pkg::ALU_ADD;
    o_ctrl.br_func = f3;
    o_ctrl.mem_op = f3; // width and sign straight from funct3
    case (i_inst.r.opcode)
      `OPC_LUI: begin
        o_ctrl.rd = i_inst.u.rd;
        o_ctrl.imm = imm_u;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.alu_op = id_pkg::ALU_PASS_B;
        o_ctrl.gpr_wen = 1'b1;
      end
      `OPC_AUIPC: begin
        o_ctrl.rd = i_inst.u.rd;
        o_ctrl.imm = imm_u;
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.gpr_wen = 1'b1;
      end
      `OPC_JAL: begin
        o_ctrl.rd = i_inst.j.rd;
        o_ctrl.imm = imm_j;
        o_ctrl.alu_src1_sel = 1'b1; // link value pc+4
        o_ctrl.alu_src2_sel = 2'd2;
        o_ctrl.br_kind = id_pkg::BR_JAL;
        o_ctrl.gpr_wen = 1'b1;
      end
      `OPC_JALR: begin
        o_ctrl.rd = i_inst.i.rd;
        o_ctrl.rs1 = i_inst.i.rs1;
        o_ctrl.imm = imm_i;
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = 2'd2;
        o_ctrl.br_kind = id_pkg::BR_JALR;
        o_ctrl.gpr_wen = 1'b1;
        ok = (f3 == 3'b000);
      end
      `OPC_BRANCH: begin
        o_ctrl.rs1 = i_inst.b.rs1;
        o_ctrl.rs2 = i_inst.b.rs2;
        o_ctrl.imm = imm_b;
        o_ctrl.br_kind = id_pkg::BR_COND;
        ok = (f3[2:1] != 2'b01);
      end
      `OPC_LOAD: begin
        o_ctrl.rd = i_inst.i.rd;
        o_ctrl.rs1 = i_inst.i.rs1;
        o_ctrl.imm = imm_i;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.mem_ren = 1'b1;
        o_ctrl.load_sel = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
        ok = (f3 != 3'b111);
      end
      `OPC_STORE: begin
        o_ctrl.rs1 = i_inst.s.rs1;
        o_ctrl.rs2 = i_inst.s.rs2;
        o_ctrl.imm = imm_s;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.mem_wen = 1'b1;
        ok = !f3[2]; // sb..sd
      end
      `OPC_OPIMM, `OPC_OPIMM32: begin
        o_ctrl.rd = i_inst.i.rd;
        o_ctrl.rs1 = i_inst.i.rs1;
        o_ctrl.imm = imm_i;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.alu_op = alu_dec(f3, f3 == 3'b101 && f7[5]);
        o_ctrl.alu_word_cut = (i_inst.r.opcode == `OPC_OPIMM32);
        o_ctrl.gpr_wen = 1'b1;
        if (i_inst.r.opcode == `OPC_OPIMM) begin
          ok = sh_ok;
        end else begin
          ok = (f3 == 3'b000) || ((f3 == 3'b001 || f3 == 3'b101) && op_ok);
        end
      end
      `OPC_OP, `OPC_OP32: begin
        o_ctrl.rd = i_inst.r.rd;
        o_ctrl.rs1 = i_inst.r.rs1;
        o_ctrl.rs2 = i_inst.r.rs2;
        o_ctrl.alu_op = alu_dec(f3, f7[5]);
        o_ctrl.alu_word_cut = (i_inst.r.opcode == `OPC_OP32);
        o_ctrl.gpr_wen = 1'b1;
        ok = op_ok && (i_inst.r.opcode == `OPC_OP ||
                       f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101);
      end
      `OPC_SYSTEM: begin
        ok = (i_inst == `EBREAK_INST);
        o_ctrl.ebreak_sel = ok;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      o_ctrl.br_kind = id_pkg::BR_NONE;
      o_ctrl.gpr_wen = 1'b0;
      o_ctrl.mem_ren = 1'b0;
      o_ctrl.mem_wen = 1'b0;
      o_ctrl.load_sel = 1'b0;
      o_ctrl.invalid_sel = 1'b1;
    end
  end

  always_comb begin
    a_mem_excl: assert final (!(o_ctrl.mem_ren && o_ctrl.mem_wen))
      else $error("load and store decoded together");
  end

endmodule

`default_nettype wire

//--- verilog/id_gpr.sv
// 32 x 64 register file, x0 hardwired to zero, write visible from the cycle after the edge
`default_nettype none
`timescale 1ns/1ns
`include "id_defs.svh"

module id_gpr (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr2,
  input  id_pkg::rf_wr_t          i_wr,
  output logic [`XLEN-1:0]        o_rdata1,
  output logic [`XLEN-1:0]        o_rdata2
);

  logic [`XLEN-1:0] regs [`GPR_NUM];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int k = 0; k < `GPR_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin // x0 ignores writes
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // write-back stage must name a real register whenever it writes
  a_waddr_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wr.wen |-> !$isunknown(i_wr.waddr));

endmodule

`default_nettype wire

//--- verilog/id_pkg.sv
// decode stage types; no csr fields are carried on any bus
`default_nettype none
`include "id_defs.svh"

package id_pkg;

  typedef struct packed {
    logic [6:0]              funct7;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [2:0]              funct3;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [6:0]              opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]             imm;
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [2:0]              funct3;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [6:0]              opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]              imm_hi;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [2:0]              funct3;
    logic [4:0]              imm_lo;
    logic [6:0]              opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                    imm12;
    logic [5:0]              imm10_5;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [2:0]              funct3;
    logic [3:0]              imm4_1;
    logic                    imm11;
    logic [6:0]              opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]             imm;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [6:0]              opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                    imm20;
    logic [9:0]              imm10_1;
    logic                    imm11;
    logic [7:0]              imm19_12;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [6:0]              opcode;
  } j_fmt_t;

  // one word, read as whichever format the opcode names
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE, BR_COND, BR_JAL, BR_JALR
  } br_kind_e;

  typedef struct packed {
    logic [`INST_WD-1:0] inst;
    logic [`XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                    wen;
    logic [`GPR_ADDR_WD-1:0] waddr;
    logic [`XLEN-1:0]        wdata;
  } rf_wr_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        result;
  } bypass_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        imm;
    br_kind_e                br_kind;
    logic [2:0]              br_func;
    logic                    alu_src1_sel; // 0 rs1, 1 pc
    logic [1:0]              alu_src2_sel; // 0 rs2, 1 imm, 2 const 4
    logic                    alu_word_cut;
    alu_op_e                 alu_op;
    logic                    gpr_wen;
    logic                    mem_ren;
    logic                    mem_wen;
    logic [2:0]              mem_op;
    logic                    load_sel;
    logic                    ebreak_sel;
    logic                    invalid_sel;
  } ctrl_t;

  typedef struct packed {
    logic                    load_sel;
    logic [`XLEN-1:0]        rs1data;
    logic [`XLEN-1:0]        rs2data;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        pc;
    logic                    alu_src1_sel;
    logic [1:0]              alu_src2_sel;
    logic                    alu_word_cut;
    alu_op_e                 alu_op;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_wen;
    logic                    mem_ren;
    logic                    mem_wen;
    logic [2:0]              mem_op;
    logic                    ebreak_sel;
    logic                    invalid_sel;
  } ds_to_es_t;

  typedef struct packed {
    logic             taken;
    logic             sel;
    logic [`XLEN-1:0] target;
  } br_bus_t;

endpackage

`default_nettype wire

//--- verilog/id_defs.svh
// widths and encodings for the rv64i decode stage; only the opcodes below are decoded
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define XLEN        64
`define INST_WD     32
`define GPR_ADDR_WD 5
`define GPR_NUM     32
`define GPR_A0      5'd10

`define NOP_INST    32'h0000_0013 // addi x0,x0,0
`define EBREAK_INST 32'h0010_0073

// base opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OPIMM   7'b0010011
`define OPC_OP      7'b0110011
`define OPC_OPIMM32 7'b0011011
`define OPC_OP32    7'b0111011
`define OPC_SYSTEM  7'b1110011

`endif
